/* Bender.yml */
package:
  name: host_domain

sources:
  - host_pkg.sv
  - l2_bank.sv
  - l2_interconnect.sv
  - evt_propagator_rx.sv
  - host_ctrl_regs.sv
  - host_domain.sv
  - target: test
    files:
      - tb_host_domain_assert.sv
      - tb_host_domain.sv

/* evt_propagator_rx.sv */
/*
 * Receiver side of the cluster DMA event edge propagator
 */
`timescale 1ns/1ps

module evt_propagator_rx (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic valid_i,
  output logic ack_o,
  output logic pulse_o
);

  logic [1:0] sync_q;
  logic       ack_prev_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sync_q     <= 2'b00;
      ack_prev_q <= 1'b0;
    end else begin
      sync_q     <= {sync_q[0], valid_i};   // cluster side is asynchronous
      ack_prev_q <= sync_q[1];
    end
  end

  assign ack_o = sync_q[1];

  // One cycle per event, on the rising ack
  assign pulse_o = sync_q[1] & ~ack_prev_q;

endmodule

/* host_ctrl_regs.sv */
/*
 * Configuration slave: event status, irq enable, doorbell, scratch,
 * fixed pattern response for unmapped indices
 */
`timescale 1ns/1ps

module host_ctrl_regs (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               req_i,
  input  host_pkg::cfg_req_t cfg_i,
  output logic               ack_o,
  output host_pkg::cfg_rsp_t rsp_o,
  input  logic               evt_pulse_i,
  output logic               h2c_irq_o,
  output logic               evt_irq_o
);
  import host_pkg::*;

  logic     req_q;
  logic     ack_q;
  logic     fire;
  logic     wr;
  logic     status_q;
  logic     irq_en_q;
  logic     doorbell_q;
  logic     evt_irq_q;
  l2_data_t scratch_q;
  cfg_rsp_t rsp_d;
  cfg_rsp_t rsp_q;

  // Access happens once, on the edge that raises ack
  assign fire = req_q & ~ack_q;
  assign wr   = fire & cfg_i.we;

  always_comb begin
    rsp_d.rdata = '0;
    rsp_d.err   = 1'b0;
    case (cfg_i.reg_idx)
      REG_EVT_STATUS: rsp_d.rdata[0] = status_q;
      REG_IRQ_EN:     rsp_d.rdata[0] = irq_en_q;
      REG_DOORBELL:   rsp_d.rdata[0] = doorbell_q;
      REG_SCRATCH:    rsp_d.rdata    = scratch_q;
      default: begin
        rsp_d.rdata = CFG_UNMAPPED_DATA;
        rsp_d.err   = 1'b1;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      req_q      <= 1'b0;
      ack_q      <= 1'b0;
      status_q   <= 1'b0;
      irq_en_q   <= 1'b0;
      doorbell_q <= 1'b0;
      scratch_q  <= '0;
      evt_irq_q  <= 1'b0;
    end else begin
      req_q <= req_i;
      if (fire) begin
        ack_q <= 1'b1;
      end else if (!req_q) begin
        ack_q <= 1'b0;
      end

      // Set wins over a write-1 clear
      if (evt_pulse_i) begin
        status_q <= 1'b1;
      end else if (wr && cfg_i.reg_idx == REG_EVT_STATUS && cfg_i.wdata[0]) begin
        status_q <= 1'b0;
      end

      if (wr && cfg_i.reg_idx == REG_IRQ_EN)   irq_en_q   <= cfg_i.wdata[0];
      if (wr && cfg_i.reg_idx == REG_DOORBELL) doorbell_q <= cfg_i.wdata[0];
      if (wr && cfg_i.reg_idx == REG_SCRATCH)  scratch_q  <= cfg_i.wdata;

      evt_irq_q <= status_q & irq_en_q;
    end
  end

  // Response held while ack is high
  always_ff @(posedge clk_i) begin
    if (fire) rsp_q <= rsp_d;
  end

  assign ack_o     = ack_q;
  assign rsp_o     = rsp_q;
  assign h2c_irq_o = doorbell_q;
  assign evt_irq_o = evt_irq_q;

endmodule

/* host_domain.sv */
/*
 * Host domain top: L2 scratchpad, configuration slave, cluster event receiver
 */
`timescale 1ns/1ps

module host_domain #(
  parameter int unsigned NbBanks   = 8,   // power of two
  parameter int unsigned BankWords = 256  // power of two
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // L2 memory port
  input  logic               mem_req_i,
  input  host_pkg::mem_req_t mem_i,
  output logic               mem_ack_o,
  output host_pkg::l2_data_t mem_rdata_o,
  // Configuration port
  input  logic               cfg_req_i,
  input  host_pkg::cfg_req_t cfg_i,
  output logic               cfg_ack_o,
  output host_pkg::cfg_rsp_t cfg_o,
  // Cluster DMA event
  input  logic               dma_pe_evt_valid_i,
  output logic               dma_pe_evt_ack_o,
  output logic               h2c_irq_o,
  output logic               evt_irq_o
);

  logic dma_pe_evt;

  l2_interconnect #(
    .NbBanks   ( NbBanks   ),
    .BankWords ( BankWords )
  ) l2_interconnect_i (
    .clk_i   ( clk_i       ),
    .rst_n_i ( rst_n_i     ),
    .req_i   ( mem_req_i   ),
    .mem_i   ( mem_i       ),
    .ack_o   ( mem_ack_o   ),
    .rdata_o ( mem_rdata_o )
  );

  evt_propagator_rx ep_dma_pe_evt_i (
    .clk_i   ( clk_i              ),
    .rst_n_i ( rst_n_i            ),
    .valid_i ( dma_pe_evt_valid_i ),
    .ack_o   ( dma_pe_evt_ack_o   ),
    .pulse_o ( dma_pe_evt         )
  );

  host_ctrl_regs host_ctrl_regs_i (
    .clk_i       ( clk_i      ),
    .rst_n_i     ( rst_n_i    ),
    .req_i       ( cfg_req_i  ),
    .cfg_i       ( cfg_i      ),
    .ack_o       ( cfg_ack_o  ),
    .rsp_o       ( cfg_o      ),
    .evt_pulse_i ( dma_pe_evt ),
    .h2c_irq_o   ( h2c_irq_o  ),
    .evt_irq_o   ( evt_irq_o  )
  );

endmodule

/* host_pkg.sv */
/*
 * Shared types for the host domain: L2 word and byte-enable types,
 * memory and configuration request/response structs, register and FSM enums.
 */
package host_pkg;

  localparam int unsigned L2_DATA_WIDTH   = 32;
  localparam int unsigned HOST_ADDR_WIDTH = 32;

  typedef logic [L2_DATA_WIDTH-1:0]   l2_data_t;
  typedef logic [L2_DATA_WIDTH/8-1:0] l2_be_t;

  // Memory port request, 69 bits
  typedef struct packed {
    logic [HOST_ADDR_WIDTH-1:0] addr;   // byte address
    logic                       we;
    l2_be_t                     be;
    l2_data_t                   wdata;
  } mem_req_t;

  // Register index
  // Three bits wide so that indices 4 to 7 can reach the unmapped response
  typedef enum logic [2:0] {
    REG_EVT_STATUS = 3'd0,
    REG_IRQ_EN     = 3'd1,
    REG_DOORBELL   = 3'd2,
    REG_SCRATCH    = 3'd3
  } cfg_reg_e;

  typedef struct packed {
    cfg_reg_e reg_idx;
    logic     we;
    l2_data_t wdata;
  } cfg_req_t;

  typedef struct packed {
    l2_data_t rdata;
    logic     err;     // unmapped index
  } cfg_rsp_t;

  // Memory port handshake FSM
  typedef enum logic [1:0] {
    MS_IDLE,
    MS_ACCESS,
    MS_RESP,
    MS_RELEASE
  } mem_state_e;

  // Read pattern of the cache config stub
  localparam l2_data_t CFG_UNMAPPED_DATA = 32'hDEADF000;

endpackage

/* l2_bank.sv */
/*
 * Single-port L2 SRAM bank, byte-enabled write, registered read
 */
`timescale 1ns/1ps

module l2_bank #(
  parameter int unsigned BankWords = 256
) (
  input  logic                         clk_i,
  input  logic                         en_i,
  input  logic                         we_i,
  input  host_pkg::l2_be_t             be_i,
  input  logic [$clog2(BankWords)-1:0] row_i,
  input  host_pkg::l2_data_t           wdata_i,
  output host_pkg::l2_data_t           rdata_o
);
  import host_pkg::*;

  logic [L2_DATA_WIDTH-1:0] mem_q [BankWords];
  l2_data_t                 merged;

  // Byte lane merge with the stored word
  always_comb begin
    merged = mem_q[row_i];
    for (int b = 0; b < L2_DATA_WIDTH / 8; b++) begin
      if (be_i[b]) merged[8*b +: 8] = wdata_i[8*b +: 8];
    end
  end

  always_ff @(posedge clk_i) begin
    if (en_i) begin
      if (we_i) begin
        mem_q[row_i] <= merged;
        rdata_o      <= merged;      // write returns the new word
      end else begin
        rdata_o <= mem_q[row_i];
      end
    end
  end

endmodule

/* l2_interconnect.sv */
/*
 * L2 word-interleaved bank array with the four-phase req/ack memory port
 */
`timescale 1ns/1ps

module l2_interconnect #(
  parameter int unsigned NbBanks   = 8,
  parameter int unsigned BankWords = 256
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               req_i,
  input  host_pkg::mem_req_t mem_i,
  output logic               ack_o,
  output host_pkg::l2_data_t rdata_o
);
  import host_pkg::*;

  localparam int unsigned BankSelW = $clog2(NbBanks);
  localparam int unsigned RowW     = $clog2(BankWords);

  mem_state_e          state_q, state_d;
  mem_req_t            req_q;
  logic                ack_q;
  l2_data_t            rdata_q;
  logic [BankSelW-1:0] bank_sel;
  logic [RowW-1:0]     row;
  l2_data_t            bank_rdata [NbBanks];

  // Word address split, bank is the low part
  assign bank_sel = req_q.addr[2 +: BankSelW];
  assign row      = req_q.addr[2 + BankSelW +: RowW];

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      MS_IDLE:    if (req_i && !ack_q) state_d = MS_ACCESS;
      MS_ACCESS:  state_d = MS_RESP;                 // bank enabled here
      MS_RESP:    state_d = MS_RELEASE;
      MS_RELEASE: if (!req_i) state_d = MS_IDLE;
      default:    state_d = MS_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= MS_IDLE;
      ack_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == MS_RESP) begin
        ack_q <= 1'b1;
      end else if (state_q == MS_IDLE) begin
        ack_q <= 1'b0;   // one cycle after release
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == MS_IDLE && req_i && !ack_q) req_q <= mem_i;
    if (state_q == MS_RESP) rdata_q <= bank_rdata[bank_sel];
  end

  for (genvar i = 0; i < NbBanks; i++) begin : gen_banks
    l2_bank #(
      .BankWords ( BankWords )
    ) l2_bank_i (
      .clk_i   ( clk_i                                   ),
      .en_i    ( (state_q == MS_ACCESS) && (bank_sel == i) ),
      .we_i    ( req_q.we                                ),
      .be_i    ( req_q.be                                ),
      .row_i   ( row                                     ),
      .wdata_i ( req_q.wdata                             ),
      .rdata_o ( bank_rdata[i]                           )
    );
  end

  assign ack_o   = ack_q;
  assign rdata_o = rdata_q;

endmodule

/* list.f */
host_pkg.sv
l2_bank.sv
l2_interconnect.sv
evt_propagator_rx.sv
host_ctrl_regs.sv
host_domain.sv
tb_host_domain_assert.sv
tb_host_domain.sv

/* tb_host_domain.sv */
/*
 * Testbench for host_domain: clock and reset, handshake tasks,
 * L2 reference model, config and cluster event scenarios, timeout
 */
`timescale 1ns/1ps

module tb_host_domain;
  import host_pkg::*;

  localparam int unsigned NbBanks        = 8;
  localparam int unsigned BankWords      = 256;
  localparam int unsigned NumAddr        = 64;
  localparam int unsigned NumPartial     = 72;
  localparam int unsigned NumScratch     = 12;
  localparam int unsigned TimeoutCycles  = 4000;  // 240 transactions of 8 cycles max plus margin

  logic     clk;
  logic     rst_n;
  logic     mem_req;
  mem_req_t mem_cmd;
  logic     mem_ack;
  l2_data_t mem_rdata;
  logic     cfg_req;
  cfg_req_t cfg_cmd;
  logic     cfg_ack;
  cfg_rsp_t cfg_rsp;
  logic     evt_valid;
  logic     evt_ack;
  logic     h2c_irq;
  logic     evt_irq;

  logic [31:0] lcg_state = 32'd22184;
  int unsigned cycle_cnt = 0;
  l2_data_t    ref_mem [NbBanks*BankWords];
  logic [31:0] addr_tab [NumAddr];

  host_domain #(
    .NbBanks   ( NbBanks   ),
    .BankWords ( BankWords )
  ) host_domain_i (
    .clk_i              ( clk       ),
    .rst_n_i            ( rst_n     ),
    .mem_req_i          ( mem_req   ),
    .mem_i              ( mem_cmd   ),
    .mem_ack_o          ( mem_ack   ),
    .mem_rdata_o        ( mem_rdata ),
    .cfg_req_i          ( cfg_req   ),
    .cfg_i              ( cfg_cmd   ),
    .cfg_ack_o          ( cfg_ack   ),
    .cfg_o              ( cfg_rsp   ),
    .dma_pe_evt_valid_i ( evt_valid ),
    .dma_pe_evt_ack_o   ( evt_ack   ),
    .h2c_irq_o          ( h2c_irq   ),
    .evt_irq_o          ( evt_irq   )
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
      $display("STATUS: FAIL");
      $fatal(1, "timeout");
    end
    if (host_domain_i.host_domain_assert_i.fail_cnt != 0) begin
      $display("A concurrent assertion on the DUT ports failed");
      $display("STATUS: FAIL");
      $fatal(1, "assertion failure");
    end
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state ^ (lcg_state >> 15);   // fold high bits into the weak low ones
  endfunction

  // Bank from the low word address bits and row above it
  function automatic int unsigned model_index(logic [31:0] addr);
    int unsigned w;
    int unsigned bank;
    int unsigned row;
    w    = addr >> 2;
    bank = w % NbBanks;
    row  = (w / NbBanks) % BankWords;
    return row * NbBanks + bank;
  endfunction

  function automatic l2_data_t merge_bytes(l2_data_t old, l2_data_t wdata, l2_be_t be);
    l2_data_t res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) res[8*b +: 8] = wdata[8*b +: 8];
    end
    return res;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("[FAIL] t=%0t %s expected %08h actual %08h", $time, name, exp, act);
      $display("STATUS: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic wait_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic mem_access(input logic we, input logic [31:0] addr, input l2_be_t be,
                            input l2_data_t wdata, output l2_data_t rdata);
    mem_cmd.addr  = addr;
    mem_cmd.we    = we;
    mem_cmd.be    = be;
    mem_cmd.wdata = wdata;
    mem_req       = 1'b1;
    do wait_cycle(); while (!mem_ack);
    rdata   = mem_rdata;
    mem_req = 1'b0;
    do wait_cycle(); while (mem_ack);
  endtask

  task automatic cfg_access(input logic [2:0] idx, input logic we, input l2_data_t wdata,
                            output cfg_rsp_t rsp);
    cfg_cmd.reg_idx = cfg_reg_e'(idx);
    cfg_cmd.we      = we;
    cfg_cmd.wdata   = wdata;
    cfg_req         = 1'b1;
    do wait_cycle(); while (!cfg_ack);
    rsp     = cfg_rsp;
    cfg_req = 1'b0;
    do wait_cycle(); while (cfg_ack);
  endtask

  task automatic send_cluster_event();
    evt_valid = 1'b1;
    do wait_cycle(); while (!evt_ack);
    evt_valid = 1'b0;
    do wait_cycle(); while (evt_ack);
  endtask

  initial begin
    l2_data_t    rdata;
    l2_data_t    wdata;
    l2_data_t    exp;
    l2_be_t      be;
    logic [31:0] addr;
    int unsigned idx;
    cfg_rsp_t    rsp;

    clk       = 1'b0;
    rst_n     = 1'b0;
    mem_req   = 1'b0;
    mem_cmd   = '0;
    cfg_req   = 1'b0;
    cfg_cmd   = '0;
    evt_valid = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Full-word fill where the first NbBanks entries cover every bank
    for (int i = 0; i < NumAddr; i++) begin
      addr_tab[i] = (next_rand() & ~(NbBanks * 4 - 1)) | ((i % NbBanks) << 2);
      wdata       = next_rand();
      idx         = model_index(addr_tab[i]);
      mem_access(1'b1, addr_tab[i], 4'hF, wdata, rdata);
      ref_mem[idx] = wdata;
      check_value("mem_rdata_o", wdata, rdata);
    end

    for (int i = 0; i < NumPartial; i++) begin
      addr  = addr_tab[next_rand() % NumAddr];
      wdata = next_rand();
      be    = next_rand() & 4'hF;
      idx   = model_index(addr);
      exp   = merge_bytes(ref_mem[idx], wdata, be);
      mem_access(1'b1, addr, be, wdata, rdata);
      ref_mem[idx] = exp;
      check_value("mem_rdata_o", exp, rdata);
    end

    for (int i = 0; i < NumAddr; i++) begin
      mem_access(1'b0, addr_tab[i], 4'h0, '0, rdata);
      check_value("mem_rdata_o", ref_mem[model_index(addr_tab[i])], rdata);
    end

    // Scratch register round trip
    for (int i = 0; i < NumScratch; i++) begin
      wdata = next_rand();
      cfg_access(3'd3, 1'b1, wdata, rsp);
      cfg_access(3'd3, 1'b0, '0, rsp);
      check_value("cfg_o.rdata", wdata, rsp.rdata);
      check_value("cfg_o.err", 1'b0, rsp.err);
    end

    for (int i = 4; i < 8; i++) begin
      cfg_access(i[2:0], 1'b0, '0, rsp);
      check_value("cfg_o.rdata", 32'hDEADF000, rsp.rdata);
      check_value("cfg_o.err", 1'b1, rsp.err);
    end
    cfg_access(3'd7, 1'b1, ~wdata, rsp);  // shares its low index bits with scratch
    cfg_access(3'd3, 1'b0, '0, rsp);
    check_value("cfg_o.rdata", wdata, rsp.rdata);

    // Cluster DMA event, status and interrupt
    send_cluster_event();
    cfg_access(3'd0, 1'b0, '0, rsp);
    check_value("cfg_o.rdata", 32'h1, rsp.rdata);
    check_value("evt_irq_o", 1'b0, evt_irq);
    cfg_access(3'd1, 1'b1, 32'h1, rsp);
    check_value("evt_irq_o", 1'b1, evt_irq);
    cfg_access(3'd0, 1'b1, 32'h1, rsp);
    check_value("evt_irq_o", 1'b0, evt_irq);
    cfg_access(3'd0, 1'b0, '0, rsp);
    check_value("cfg_o.rdata", 32'h0, rsp.rdata);
    cfg_access(3'd1, 1'b1, 32'h0, rsp);

    // Doorbell
    cfg_access(3'd2, 1'b1, 32'h1, rsp);
    check_value("h2c_irq_o", 1'b1, h2c_irq);
    cfg_access(3'd2, 1'b0, '0, rsp);
    check_value("cfg_o.rdata", 32'h1, rsp.rdata);
    cfg_access(3'd2, 1'b1, 32'h0, rsp);
    check_value("h2c_irq_o", 1'b0, h2c_irq);

    wait_cycle();
    if (host_domain_i.host_domain_assert_i.fail_cnt == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      $display("A concurrent assertion on the DUT ports failed");
      $display("STATUS: FAIL");
      $fatal(1, "assertion failure");
    end
  end

endmodule

/* tb_host_domain_assert.sv */
/*
 * Port-level concurrent checks for host_domain, attached by bind
 */
`timescale 1ns/1ps

module host_domain_assert (
  input logic               clk_i,
  input logic               rst_n_i,
  input logic               mem_req_i,
  input logic               mem_ack_o,
  input logic               cfg_req_i,
  input host_pkg::cfg_req_t cfg_i,
  input logic               cfg_ack_o,
  input logic               dma_pe_evt_valid_i,
  input logic               dma_pe_evt_ack_o,
  input logic               h2c_irq_o,
  input logic               evt_irq_o
);
  import host_pkg::*;

  int unsigned fail_cnt = 0;

  reset_outputs_low: assert property (@(posedge clk_i)
    !rst_n_i |=> !mem_ack_o && !cfg_ack_o && !dma_pe_evt_ack_o && !h2c_irq_o && !evt_irq_o)
    else begin
      $error("acks or interrupts not low after reset");
      fail_cnt++;
    end

  // Ack registered two edges after req is taken and seen one edge later
  mem_ack_rise: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(mem_req_i) |-> ##3 $rose(mem_ack_o))
    else begin
      $error("memory ack did not rise 2 cycles after req");
      fail_cnt++;
    end

  mem_ack_fall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $fell(mem_req_i) |-> ##2 $fell(mem_ack_o))
    else begin
      $error("memory ack did not fall 1 cycle after req");
      fail_cnt++;
    end

  mem_ack_no_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !mem_req_i && !mem_ack_o |=> !mem_ack_o)
    else begin
      $error("memory ack rose without a request");
      fail_cnt++;
    end

  cfg_ack_rise: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(cfg_req_i) |-> ##2 $rose(cfg_ack_o))
    else begin
      $error("config ack did not rise 1 cycle after req");
      fail_cnt++;
    end

  cfg_ack_fall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $fell(cfg_req_i) |-> ##2 $fell(cfg_ack_o))
    else begin
      $error("config ack did not fall 1 cycle after req");
      fail_cnt++;
    end

  evt_ack_rise: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(dma_pe_evt_valid_i) |-> ##2 $rose(dma_pe_evt_ack_o))
    else begin
      $error("cluster event ack does not rise after valid");
      fail_cnt++;
    end

  evt_ack_fall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $fell(dma_pe_evt_valid_i) |-> ##2 $fell(dma_pe_evt_ack_o))
    else begin
      $error("cluster event ack does not fall after valid");
      fail_cnt++;
    end

  // Doorbell output updates on the same edge as the ack
  doorbell_at_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(cfg_ack_o) && cfg_i.we && cfg_i.reg_idx == REG_DOORBELL |-> h2c_irq_o == cfg_i.wdata[0])
    else begin
      $error("h2c interrupt does not match the doorbell write");
      fail_cnt++;
    end

endmodule

bind host_domain host_domain_assert host_domain_assert_i (.*);
